// ==== i2c_macros.svh ====
`ifndef I2C_MACROS_SVH
`define I2C_MACROS_SVH

// APB side
`define I2C_APB_AW 5

// Register map, byte offsets
`define I2C_REG_CMD      5'h00   // [7:1] target address, [0] rw
`define I2C_REG_TXDATA   5'h04
`define I2C_REG_RXDATA   5'h08   // Read only
`define I2C_REG_STATUS   5'h0C   // Write 1 to clear done and nack
`define I2C_REG_PRESCALE 5'h10

// Quarter SCL period is PRESCALE+1 clk cycles
`define I2C_PRESCALE_W 16

// 100 kHz SCL from a 50 MHz clk
`define I2C_PRESCALE_DEFAULT 16'd124

`endif

// ==== i2c_pkg.sv ====
package i2c_pkg;

    // Command from the register block, start is a one cycle pulse
    typedef struct packed {
        logic       start;
        logic [6:0] addr;
        logic       rw;     // 1 = read
        logic [7:0] txdata;
    } i2c_cmd_t;

    // Engine response, nack and rxdata are valid with done
    typedef struct packed {
        logic       busy;
        logic       done;
        logic       nack;
        logic [7:0] rxdata;
    } i2c_rsp_t;

    // STATUS register, busy lands in bit 0
    typedef struct packed {
        logic nack;
        logic done;
        logic busy;
    } i2c_status_t;

    typedef struct packed {
        logic [6:0] addr;
        logic       rw;
    } i2c_addr_byte_t;

    // Same byte seen as address phase or as data phase
    typedef union packed {
        i2c_addr_byte_t ab;
        logic [7:0]     data;
    } i2c_shift_u;

    typedef enum logic [3:0] {
        IDLE,
        START,
        ADDR,
        ACK_ADDR,
        WRITE_DATA,
        ACK_WRITE,
        READ_DATA,
        SEND_NACK,
        STOP
    } i2c_state_e;

endpackage

// ==== i2c_bit_timer.sv ====
`timescale 1ns/1ps
`include "i2c_macros.svh"

module i2c_bit_timer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        run,
    input  logic [`I2C_PRESCALE_W-1:0]  prescale,
    output logic                        qtick
);

    logic [`I2C_PRESCALE_W-1:0] cnt;

    // Held in reload while idle so the first quarter is full length
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (!run) begin
            cnt <= prescale;
        end else if (cnt == '0) begin
            cnt <= prescale;            // New prescale takes effect here
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    assign qtick = run && (cnt == '0);

    a_no_tick_idle: assert property (@(posedge clk) disable iff (rst)
        !run |-> !qtick);

endmodule

// ==== i2c_regs.sv ====
`timescale 1ns/1ps
`include "i2c_macros.svh"

module i2c_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`I2C_APB_AW-1:0]      paddr,
    input  logic [31:0]                 pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr,
    output i2c_pkg::i2c_cmd_t           cmd,
    input  i2c_pkg::i2c_rsp_t           rsp,
    output logic [`I2C_PRESCALE_W-1:0]  prescale
);

    logic [6:0] addr_q;
    logic       rw_q;
    logic [7:0] txdata_q;
    logic [7:0] rxdata_q;
    logic       start_q;
    logic       done_q;
    logic       nack_q;
    logic       access;
    logic       wr;
    logic       addr_hit;
    logic       busy_any;
    logic       cmd_wr;
    logic       reject;
    logic       clr_wr;
    i2c_pkg::i2c_status_t status;

    assign pready   = 1'b1;                 // No wait states
    assign access   = psel & penable;
    assign wr       = access & pwrite;
    assign busy_any = rsp.busy | start_q;   // Covers the cycle before busy rises
    assign cmd_wr   = wr && (paddr == `I2C_REG_CMD);
    assign reject   = cmd_wr & busy_any;
    assign clr_wr   = wr && (paddr == `I2C_REG_STATUS);

    assign addr_hit = paddr inside {`I2C_REG_CMD, `I2C_REG_TXDATA, `I2C_REG_RXDATA,
                                    `I2C_REG_STATUS, `I2C_REG_PRESCALE};
    assign pslverr  = access & (~addr_hit | reject);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr_q   <= '0;
            rw_q     <= 1'b0;
            txdata_q <= '0;
            start_q  <= 1'b0;
            prescale <= `I2C_PRESCALE_DEFAULT;
        end else begin
            start_q <= 1'b0;
            if (cmd_wr && !busy_any) begin  // Launch
                addr_q  <= pwdata[7:1];
                rw_q    <= pwdata[0];
                start_q <= 1'b1;
            end
            if (wr && paddr == `I2C_REG_TXDATA)
                txdata_q <= pwdata[7:0];
            if (wr && paddr == `I2C_REG_PRESCALE)
                prescale <= pwdata[`I2C_PRESCALE_W-1:0];
        end
    end

    // Sticky result bits, a done from the engine wins over a clear
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rxdata_q <= '0;
            done_q   <= 1'b0;
            nack_q   <= 1'b0;
        end else if (rsp.done) begin
            rxdata_q <= rsp.rxdata;
            done_q   <= 1'b1;
            nack_q   <= rsp.nack;
        end else if (clr_wr) begin
            if (pwdata[1]) done_q <= 1'b0;
            if (pwdata[2]) nack_q <= 1'b0;
        end
    end

    always_comb begin
        status.busy = rsp.busy;
        status.done = done_q;
        status.nack = nack_q;
    end

    always_comb begin
        case (paddr)
            `I2C_REG_CMD:      prdata = {24'b0, addr_q, rw_q};
            `I2C_REG_TXDATA:   prdata = {24'b0, txdata_q};
            `I2C_REG_RXDATA:   prdata = {24'b0, rxdata_q};
            `I2C_REG_STATUS:   prdata = {29'b0, status};
            `I2C_REG_PRESCALE: prdata = {{(32-`I2C_PRESCALE_W){1'b0}}, prescale};
            default:           prdata = '0;
        endcase
    end

    always_comb begin
        cmd.start  = start_q;
        cmd.addr   = addr_q;
        cmd.rw     = rw_q;
        cmd.txdata = txdata_q;
    end

    a_pready: assert property (@(posedge clk) disable iff (rst) psel |-> pready);

    // Engine must be idle whenever a launch goes out
    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        $rose(cmd.start) |-> !rsp.busy);

endmodule

// ==== i2c_master.sv ====
`timescale 1ns/1ps

module i2c_master (
    input  logic               clk,
    input  logic               rst,
    input  i2c_pkg::i2c_cmd_t  cmd,
    output i2c_pkg::i2c_rsp_t  rsp,
    input  logic               qtick,
    output logic               run,
    output logic               scl,
    output logic               sda_oe,
    input  logic               sda_in
);

    i2c_pkg::i2c_state_e state;
    i2c_pkg::i2c_shift_u shift;
    logic [1:0] quarter;    // Quarter of the current bit period
    logic [2:0] bit_cnt;
    logic       rw_q;
    logic [7:0] txdata_q;
    logic       nack;
    logic       done;
    logic       launch;

    assign launch = (state == i2c_pkg::IDLE) && cmd.start;
    assign run    = (state != i2c_pkg::IDLE);

    always_comb begin
        rsp.busy   = run;
        rsp.done   = done;
        rsp.nack   = nack;
        rsp.rxdata = shift.data;
    end

    // Bit phases: q0 SCL low, SDA moves at its end; SCL rises after q1;
    // SCL falls after q3
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= i2c_pkg::IDLE;
            quarter <= '0;
            bit_cnt <= '0;
            rw_q    <= 1'b0;
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
            nack    <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (launch) begin
                state   <= i2c_pkg::START;
                quarter <= '0;
                bit_cnt <= '0;
                rw_q    <= cmd.rw;
                nack    <= 1'b0;
            end else if (run && qtick) begin
                quarter <= quarter + 2'd1;
                case (quarter)
                    2'd0: begin
                        case (state)
                            i2c_pkg::ADDR, i2c_pkg::WRITE_DATA:
                                sda_oe <= ~shift.data[7];   // MSB first
                            i2c_pkg::STOP:
                                sda_oe <= 1'b1;     // Pull SDA low ahead of STOP
                            i2c_pkg::START: ;
                            default:
                                sda_oe <= 1'b0;     // ACK slots, read bits, NACK
                        endcase
                    end
                    2'd1: begin
                        if (state == i2c_pkg::START) begin
                            sda_oe <= 1'b1;         // START, SDA falls under high SCL
                        end else begin
                            scl <= 1'b1;
                            if ((state == i2c_pkg::ACK_ADDR ||
                                 state == i2c_pkg::ACK_WRITE) && sda_in)
                                nack <= 1'b1;
                        end
                    end
                    2'd2: begin
                        if (state == i2c_pkg::STOP)
                            sda_oe <= 1'b0;         // STOP, SDA rises under high SCL
                    end
                    default: begin
                        if (state != i2c_pkg::STOP)
                            scl <= 1'b0;
                        case (state)
                            i2c_pkg::START:
                                state <= i2c_pkg::ADDR;
                            i2c_pkg::ADDR: begin
                                bit_cnt <= bit_cnt + 3'd1;
                                if (bit_cnt == 3'd7)
                                    state <= i2c_pkg::ACK_ADDR;
                            end
                            i2c_pkg::ACK_ADDR: begin
                                if (nack)
                                    state <= i2c_pkg::STOP;     // Skip the data byte
                                else if (rw_q)
                                    state <= i2c_pkg::READ_DATA;
                                else
                                    state <= i2c_pkg::WRITE_DATA;
                            end
                            i2c_pkg::WRITE_DATA: begin
                                bit_cnt <= bit_cnt + 3'd1;
                                if (bit_cnt == 3'd7)
                                    state <= i2c_pkg::ACK_WRITE;
                            end
                            i2c_pkg::READ_DATA: begin
                                bit_cnt <= bit_cnt + 3'd1;
                                if (bit_cnt == 3'd7)
                                    state <= i2c_pkg::SEND_NACK;
                            end
                            i2c_pkg::ACK_WRITE, i2c_pkg::SEND_NACK:
                                state <= i2c_pkg::STOP;
                            default: begin
                                state <= i2c_pkg::IDLE;
                                done  <= 1'b1;      // Busy drops on this same cycle
                            end
                        endcase
                    end
                endcase
            end
        end
    end

    // Shift register and latched transmit byte
    always_ff @(posedge clk) begin
        if (launch) begin
            shift.ab.addr <= cmd.addr;
            shift.ab.rw   <= cmd.rw;
            txdata_q      <= cmd.txdata;
        end else if (run && qtick) begin
            if (quarter == 2'd0 &&
                (state == i2c_pkg::ADDR || state == i2c_pkg::WRITE_DATA))
                shift.data <= {shift.data[6:0], 1'b0};
            else if (quarter == 2'd1 && state == i2c_pkg::READ_DATA)
                shift.data <= {shift.data[6:0], sda_in};   // Sample at SCL rise
            else if (quarter == 2'd3 && state == i2c_pkg::ACK_ADDR)
                shift.data <= txdata_q;
        end
    end

    // SDA only moves under high SCL for START and STOP conditions
    a_sda_stable: assert property (@(posedge clk) disable iff (rst)
        (scl && $past(scl) &&
         !($past(state) inside {i2c_pkg::START, i2c_pkg::STOP})) |-> $stable(sda_oe));

    a_idle_hold: assert property (@(posedge clk) disable iff (rst)
        (state == i2c_pkg::IDLE && !cmd.start) |=> state == i2c_pkg::IDLE);

endmodule

// ==== i2c_top.sv ====
`timescale 1ns/1ps
`include "i2c_macros.svh"

module i2c_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`I2C_APB_AW-1:0]  paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic                    scl,
    inout  wire                     sda
);

    i2c_pkg::i2c_cmd_t cmd;
    i2c_pkg::i2c_rsp_t rsp;
    logic [`I2C_PRESCALE_W-1:0] prescale;
    logic run;
    logic qtick;
    logic sda_oe;
    logic sda_in;

    i2c_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .cmd      (cmd),
        .rsp      (rsp),
        .prescale (prescale)
    );

    i2c_bit_timer u_timer (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .prescale (prescale),
        .qtick    (qtick)
    );

    i2c_master u_master (
        .clk    (clk),
        .rst    (rst),
        .cmd    (cmd),
        .rsp    (rsp),
        .qtick  (qtick),
        .run    (run),
        .scl    (scl),
        .sda_oe (sda_oe),
        .sda_in (sda_in)
    );

    // Open drain, the pullup sits outside the chip
    assign sda    = sda_oe ? 1'b0 : 1'bz;
    assign sda_in = sda;

endmodule

// ==== tb_i2c_target.sv ====
`timescale 1ns/1ps

module tb_i2c_target (
    input  logic       scl,
    inout  wire        sda,
    input  logic [6:0] own_addr,
    input  logic [7:0] read_byte,
    output logic [7:0] addr_byte,   // Last address byte seen on the bus
    output logic [7:0] wr_byte,
    output logic       got_data,
    output logic       ninth_bit,   // Master ACK or NACK after a read byte
    output int         stop_count
);

    localparam int PH_IDLE   = 0;
    localparam int PH_ADDR   = 1;
    localparam int PH_AACK   = 2;
    localparam int PH_WDATA  = 3;
    localparam int PH_WACK   = 4;
    localparam int PH_RDATA  = 5;
    localparam int PH_MACK   = 6;
    localparam int PH_IGNORE = 7;

    int         phase;
    int         bit_cnt;
    logic [7:0] shreg;
    logic [7:0] rd_q;
    logic       drive_low;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial begin
        phase      = PH_IDLE;
        bit_cnt    = 0;
        shreg      = '0;
        rd_q       = '0;
        drive_low  = 1'b0;
        addr_byte  = '0;
        wr_byte    = '0;
        got_data   = 1'b0;
        ninth_bit  = 1'b0;
        stop_count = 0;
    end

    // START, SDA falls under high SCL
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            phase     = PH_ADDR;
            bit_cnt   = 0;
            shreg     = '0;
            got_data  = 1'b0;
            ninth_bit = 1'b0;
        end
    end

    // STOP, SDA rises under high SCL
    always @(posedge sda) begin
        if (scl === 1'b1) begin
            stop_count = stop_count + 1;
            phase      = PH_IDLE;
            drive_low  = 1'b0;
        end
    end

    always @(posedge scl) begin
        case (phase)
            PH_ADDR, PH_WDATA: begin
                shreg   = {shreg[6:0], sda};    // Sample at SCL rise
                bit_cnt = bit_cnt + 1;
            end
            PH_RDATA: bit_cnt = bit_cnt + 1;
            PH_MACK:  ninth_bit = sda;
            default: ;
        endcase
    end

    // SDA only moves while SCL is low
    always @(negedge scl) begin
        case (phase)
            PH_ADDR: begin
                if (bit_cnt == 8) begin
                    addr_byte = shreg;
                    if (shreg[7:1] == own_addr) begin
                        drive_low = 1'b1;       // ACK the address
                        phase     = PH_AACK;
                    end else begin
                        phase = PH_IGNORE;
                    end
                end
            end
            PH_AACK: begin
                bit_cnt = 0;
                if (addr_byte[0]) begin
                    rd_q      = read_byte;
                    drive_low = ~read_byte[7];
                    phase     = PH_RDATA;
                end else begin
                    drive_low = 1'b0;
                    phase     = PH_WDATA;
                end
            end
            PH_WDATA: begin
                if (bit_cnt == 8) begin
                    wr_byte   = shreg;
                    got_data  = 1'b1;
                    drive_low = 1'b1;           // ACK the data byte
                    phase     = PH_WACK;
                end
            end
            PH_WACK: begin
                drive_low = 1'b0;
                phase     = PH_IGNORE;
            end
            PH_RDATA: begin
                if (bit_cnt == 8) begin
                    drive_low = 1'b0;           // Hand SDA back for the ninth bit
                    phase     = PH_MACK;
                end else begin
                    drive_low = ~rd_q[7 - bit_cnt];
                end
            end
            PH_MACK: phase = PH_IGNORE;
            default: ;
        endcase
    end

endmodule

// ==== tb_i2c_top.sv ====
`timescale 1ns/1ps
`include "i2c_macros.svh"

module tb_i2c_top;

    localparam int MAX_PRESCALE = 7;
    // Six transactions of 20 bit periods at the slowest prescaler with a 2x margin
    localparam int WATCHDOG_NS  = 6 * 20 * 4 * (MAX_PRESCALE + 1) * 4 * 2;
    localparam int POLL_LIMIT   = 2000;

    logic                   clk;
    logic                   rst;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`I2C_APB_AW-1:0] paddr;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   scl;
    wire                    sda;

    logic [6:0]  target_addr;
    logic [7:0]  target_rdata;
    logic [7:0]  tgt_addr_byte;
    logic [7:0]  tgt_wr_byte;
    logic        tgt_got_data;
    logic        tgt_ninth_bit;
    int          tgt_stops;

    int          errors;
    int          checks;
    logic [31:0] rng;
    int          cycle_cnt;
    int          last_rise;
    int          scl_gap;
    logic        scl_q;
    logic        in_data_byte;

    pullup (sda);

    i2c_top dut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .scl     (scl),
        .sda     (sda)
    );

    tb_i2c_target u_target (
        .scl        (scl),
        .sda        (sda),
        .own_addr   (target_addr),
        .read_byte  (target_rdata),
        .addr_byte  (tgt_addr_byte),
        .wr_byte    (tgt_wr_byte),
        .got_data   (tgt_got_data),
        .ninth_bit  (tgt_ninth_bit),
        .stop_count (tgt_stops)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic apb_write(input logic [4:0] addr, input logic [31:0] data,
                             output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #1;
        err = pslverr;      // Mid access phase, well before the edge
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [4:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #1;
        data = prdata;
        err  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Polls STATUS until the sticky done bit shows up
    task automatic wait_done();
        logic [31:0] st;
        logic        err;
        int          polls;
        st    = '0;
        polls = 0;
        while (!st[1] && polls < POLL_LIMIT) begin
            apb_read(`I2C_REG_STATUS, st, err);
            polls++;
        end
        if (!st[1]) begin
            errors++;
            $display("Error at %0t ns: done never pulsed", $time);
        end
    endtask

    task automatic run_transaction(input logic [6:0] addr, input logic rw,
                                   input logic [7:0] tx);
        logic err;
        apb_write(`I2C_REG_TXDATA, {24'b0, tx}, err);
        apb_write(`I2C_REG_CMD, {24'b0, addr, rw}, err);
        expect_equal("pslverr", 0, err);
        wait_done();
    endtask

    task automatic print_counts();
        $display("Checks run: %0d, errors: %0d", checks, errors);
    endtask

    // Spacing of SCL rising edges inside a written data byte
    always @(posedge clk) begin
        if (scl && !scl_q && dut.u_master.state == i2c_pkg::WRITE_DATA) begin
            if (in_data_byte)
                scl_gap = cycle_cnt - last_rise;
            last_rise    = cycle_cnt;
            in_data_byte = 1'b1;
        end else if (dut.u_master.state != i2c_pkg::WRITE_DATA) begin
            in_data_byte = 1'b0;
        end
        scl_q     = scl;
        cycle_cnt = cycle_cnt + 1;
    end

    // No wait states on any access phase
    apb_ready: assert property (@(posedge clk) disable iff (rst)
        (psel && penable) |-> pready)
    else begin
        errors++;
        $display("CHECK FAILED at %0t ns: pready expected 1, got %b",
                 $time, $sampled(pready));
    end

    busy_with_done: assert property (@(posedge clk) disable iff (rst)
        $fell(dut.u_master.rsp.busy) |-> dut.u_master.rsp.done)
    else begin
        errors++;
        $display("CHECK FAILED at %0t ns: rsp.done expected 1, got %b",
                 $time, $sampled(dut.u_master.rsp.done));
    end

    done_in_idle: assert property (@(posedge clk) disable iff (rst)
        dut.u_master.rsp.done |-> dut.u_master.state == i2c_pkg::IDLE)
    else begin
        errors++;
        $display("CHECK FAILED at %0t ns: state expected %0d, got %0d",
                 $time, i2c_pkg::IDLE, $sampled(dut.u_master.state));
    end

    // Single byte master receiver leaves the ninth bit high
    read_nack_high: assert property (@(posedge clk) disable iff (rst)
        (dut.u_master.state == i2c_pkg::SEND_NACK && $rose(scl)) |-> sda)
    else begin
        errors++;
        $display("CHECK FAILED at %0t ns: sda expected 1, got %b", $time, $sampled(sda));
    end

    idle_bus_high: assert property (@(posedge clk) disable iff (rst)
        !dut.u_master.rsp.busy |-> (scl && sda))
    else begin
        errors++;
        $display("CHECK FAILED at %0t ns: scl expected 1, got %b, sda expected 1, got %b",
                 $time, $sampled(scl), $sampled(sda));
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        print_counts();
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] rdata;
        logic        err;
        logic [7:0]  tx;
        logic [6:0]  other_addr;
        int          stops_before;

        clk          = 1'b0;
        rst          = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        target_addr  = '0;
        target_rdata = '0;
        errors       = 0;
        checks       = 0;
        rng          = 32'h72b8_90b4;
        cycle_cnt    = 0;
        last_rise    = 0;
        scl_gap      = 0;
        scl_q        = 1'b1;
        in_data_byte = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Reset values
        apb_read(`I2C_REG_STATUS, rdata, err);
        expect_equal("STATUS", 0, rdata);
        apb_read(`I2C_REG_RXDATA, rdata, err);
        expect_equal("RXDATA", 0, rdata);
        apb_read(`I2C_REG_PRESCALE, rdata, err);
        expect_equal("PRESCALE", `I2C_PRESCALE_DEFAULT, rdata);
        expect_equal("pslverr", 0, err);
        expect_equal("scl", 1, scl);
        expect_equal("sda", 1, sda);
        apb_read(5'h14, rdata, err);
        expect_equal("pslverr", 1, err);
        expect_equal("prdata", 0, rdata);
        apb_write(`I2C_REG_PRESCALE, 32'd3, err);
        apb_read(`I2C_REG_PRESCALE, rdata, err);
        expect_equal("PRESCALE", 3, rdata);

        // Write transaction
        rng = xorshift(rng);
        target_addr = rng[6:0];
        rng = xorshift(rng);
        tx = rng[7:0];
        stops_before = tgt_stops;
        run_transaction(target_addr, 1'b0, tx);
        apb_read(`I2C_REG_STATUS, rdata, err);
        expect_equal("STATUS", 32'h2, rdata);
        expect_equal("target addr_byte", {target_addr, 1'b0}, tgt_addr_byte);
        expect_equal("target got_data", 1, tgt_got_data);
        expect_equal("target wr_byte", tx, tgt_wr_byte);
        expect_equal("target stop_count", stops_before + 1, tgt_stops);
        apb_write(`I2C_REG_STATUS, 32'h6, err);

        // Read transaction
        rng = xorshift(rng);
        target_rdata = rng[7:0];
        run_transaction(target_addr, 1'b1, 8'h00);
        apb_read(`I2C_REG_RXDATA, rdata, err);
        expect_equal("RXDATA", target_rdata, rdata);
        apb_read(`I2C_REG_STATUS, rdata, err);
        expect_equal("STATUS", 32'h2, rdata);
        expect_equal("target ninth_bit", 1, tgt_ninth_bit);
        apb_write(`I2C_REG_STATUS, 32'h6, err);

        // Address NACK with any nonzero difference in the address
        rng = xorshift(rng);
        other_addr = target_addr ^ (rng[6:0] | 7'h01);
        stops_before = tgt_stops;
        run_transaction(other_addr, 1'b0, tx);
        apb_read(`I2C_REG_STATUS, rdata, err);
        expect_equal("STATUS", 32'h6, rdata);
        expect_equal("target got_data", 0, tgt_got_data);
        expect_equal("target addr_byte", {other_addr, 1'b0}, tgt_addr_byte);
        expect_equal("target stop_count", stops_before + 1, tgt_stops);
        apb_write(`I2C_REG_STATUS, 32'h6, err);
        apb_read(`I2C_REG_STATUS, rdata, err);
        expect_equal("STATUS", 0, rdata);

        // Second CMD while the first transaction runs
        stops_before = tgt_stops;
        apb_write(`I2C_REG_TXDATA, {24'b0, tx}, err);
        apb_write(`I2C_REG_CMD, {24'b0, target_addr, 1'b0}, err);
        expect_equal("pslverr", 0, err);
        apb_write(`I2C_REG_CMD, {24'b0, other_addr, 1'b0}, err);
        expect_equal("pslverr", 1, err);
        wait_done();
        expect_equal("target stop_count", stops_before + 1, tgt_stops);
        expect_equal("target addr_byte", {target_addr, 1'b0}, tgt_addr_byte);
        apb_write(`I2C_REG_STATUS, 32'h6, err);

        // SCL period is four quarters of PRESCALE+1 cycles
        apb_write(`I2C_REG_PRESCALE, 32'd3, err);
        scl_gap = 0;
        run_transaction(target_addr, 1'b0, tx);
        expect_equal("scl period", 4 * (3 + 1), scl_gap);
        apb_write(`I2C_REG_STATUS, 32'h6, err);
        apb_write(`I2C_REG_PRESCALE, 32'd7, err);
        scl_gap = 0;
        run_transaction(target_addr, 1'b0, tx);
        expect_equal("scl period", 4 * (7 + 1), scl_gap);
        apb_write(`I2C_REG_STATUS, 32'h6, err);

        repeat (4) @(posedge clk);
        print_counts();
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== i2c_master.f ====
+incdir+.
i2c_pkg.sv
i2c_bit_timer.sv
i2c_regs.sv
i2c_master.sv
i2c_top.sv
tb_i2c_target.sv
tb_i2c_top.sv

// ==== Bender.yml ====
package:
  name: i2c_master

export_include_dirs:
  - .

sources:
  - i2c_pkg.sv
  - i2c_bit_timer.sv
  - i2c_regs.sv
  - i2c_master.sv
  - i2c_top.sv
  - target: test
    files:
      - tb_i2c_target.sv
      - tb_i2c_top.sv
